/* box_sum_top.f */
rtl/box_sum_pkg.sv
rtl/pixel_intake.sv
rtl/row_sequencer.sv
rtl/window_summer.sv
rtl/column_accumulator.sv
rtl/result_emitter.sv
rtl/box_sum_top.sv
test/box_sum_checker.sv
test/box_sum_tb.sv

/* rtl/box_sum_pkg.sv */
`default_nettype none

package box_sum_pkg;

  // ##########################################################
  // Data widths
  // ##########################################################

  parameter int pix_w = 8;  // Input pixel width.
  parameter int win   = 9;  // Horizontal window length.

  // 255 * 9 * 64 rows fits in 20 bits.
  parameter int acc_w = 20;

  // ##########################################################
  // Row sequencer states
  // ##########################################################

  typedef enum logic [2:0] {
    st_idle      = 3'd0,  // Waiting for the first pixel of a frame.
    st_clear     = 3'd1,  // Zeroing the column accumulators.
    st_row_start = 3'd2,  // Clearing the window.
    st_fill      = 3'd3,  // First win-1 pixels of a row.
    st_accum     = 3'd4,  // Full windows, one result each.
    st_finish    = 3'd5   // Frame done.
  } seq_state_e;

endpackage

`default_nettype wire

/* rtl/box_sum_top.sv */
`timescale 1ns/10ps
`default_nettype none

module box_sum_top #(
  parameter int COLS = 16,
  parameter int ROWS = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          in_req,
  input  wire logic [box_sum_pkg::pix_w-1:0] in_data,
  output logic                               in_ack,
  output logic                               out_req,
  output logic      [box_sum_pkg::acc_w-1:0] out_data,
  output logic                               out_last,
  input  wire logic                          out_ack,
  output logic                               frame_done
);

  logic                          pix_valid;
  logic [box_sum_pkg::pix_w-1:0] pix_data;
  logic                          pix_take;
  logic                          clr_en;
  logic                          ld_en;
  logic                          sum_en;
  logic                          cum_en;
  logic                          row_last;
  logic [$clog2(COLS)-1:0]       col_idx;
  logic [box_sum_pkg::acc_w-1:0] win_sum;
  logic                          res_valid;
  logic [box_sum_pkg::acc_w-1:0] res_data;
  logic                          res_last;
  logic                          res_ready;

  pixel_intake u_intake (
    .clk(clk), .rst_n(rst_n),
    .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
    .pix_take(pix_take), .pix_valid(pix_valid), .pix_data(pix_data)
  );

  row_sequencer #(.COLS(COLS), .ROWS(ROWS)) u_seq (
    .clk(clk), .rst_n(rst_n),
    .pix_valid(pix_valid), .res_ready(res_ready), .pix_take(pix_take),
    .clr_en(clr_en), .ld_en(ld_en), .sum_en(sum_en), .cum_en(cum_en),
    .row_last(row_last), .col_idx(col_idx), .frame_done(frame_done)
  );

  // The take strobe doubles as the window shift.
  window_summer u_window (
    .clk(clk), .rst_n(rst_n),
    .ld_en(ld_en), .shift_en(pix_take), .sum_en(sum_en),
    .pix_data(pix_data), .win_sum(win_sum)
  );

  column_accumulator #(.COLS(COLS)) u_columns (
    .clk(clk), .rst_n(rst_n),
    .clr_en(clr_en), .cum_en(cum_en), .row_last(row_last),
    .col_idx(col_idx), .win_sum(win_sum),
    .res_valid(res_valid), .res_data(res_data), .res_last(res_last)
  );

  result_emitter u_emitter (
    .clk(clk), .rst_n(rst_n),
    .res_valid(res_valid), .res_data(res_data), .res_last(res_last),
    .res_ready(res_ready), .out_req(out_req), .out_data(out_data),
    .out_last(out_last), .out_ack(out_ack)
  );

endmodule

`default_nettype wire

/* rtl/column_accumulator.sv */
`timescale 1ns/10ps
`default_nettype none

module column_accumulator #(
  parameter int COLS = 16
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          clr_en,
  input  wire logic                          cum_en,
  input  wire logic                          row_last,
  input  wire logic [$clog2(COLS)-1:0]       col_idx,
  input  wire logic [box_sum_pkg::acc_w-1:0] win_sum,
  output logic                               res_valid,
  output logic      [box_sum_pkg::acc_w-1:0] res_data,
  output logic                               res_last
);

  localparam int col_w     = $clog2(COLS);
  localparam int first_col = box_sum_pkg::win - 1;
  localparam logic [col_w-1:0] last_col = col_w'(COLS - 1);

  // Columns left of the first full window have no entry.
  logic [box_sum_pkg::acc_w-1:0] acc_mem [first_col:COLS-1];
  logic [box_sum_pkg::acc_w-1:0] acc_new;
  logic                          col_ok;

  assign col_ok  = (col_idx >= first_col);
  assign acc_new = acc_mem[col_idx] + win_sum;

  // ##########################################################
  // Accumulator array
  // ##########################################################

  always_ff @(posedge clk) begin
    if (clr_en && col_ok) begin
      acc_mem[col_idx] <= '0;  // Frame start.
    end else if (cum_en && col_ok) begin
      acc_mem[col_idx] <= acc_new;
    end
  end

  // ##########################################################
  // Result register
  // ##########################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= cum_en && col_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (cum_en) begin
      res_data <= acc_new;  // Same total as written back.
      res_last <= row_last && (col_idx == last_col);
    end
  end

endmodule

`default_nettype wire

/* rtl/pixel_intake.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_intake (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          in_req,
  input  wire logic [box_sum_pkg::pix_w-1:0] in_data,
  output logic                               in_ack,
  input  wire logic                          pix_take,
  output logic                               pix_valid,
  output logic      [box_sum_pkg::pix_w-1:0] pix_data
);

  logic buf_full;
  logic capture;

  // New request, previous handshake closed, room in the buffer.
  assign capture   = in_req && !in_ack && !buf_full;
  assign pix_valid = buf_full;

  // ##########################################################
  // Slave side of the four-phase link
  // ##########################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_ack   <= 1'b0;
      buf_full <= 1'b0;
    end else if (capture) begin
      in_ack   <= 1'b1;
      buf_full <= 1'b1;
    end else begin
      if (in_ack && !in_req) begin
        in_ack <= 1'b0;  // Request withdrawn.
      end
      if (pix_take) begin
        buf_full <= 1'b0;  // Sequencer consumed the pixel.
      end
    end
  end

  // One-entry buffer.
  always_ff @(posedge clk) begin
    if (capture) begin
      pix_data <= in_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/result_emitter.sv */
`timescale 1ns/10ps
`default_nettype none

module result_emitter (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          res_valid,
  input  wire logic [box_sum_pkg::acc_w-1:0] res_data,
  input  wire logic                          res_last,
  output logic                               res_ready,
  output logic                               out_req,
  output logic      [box_sum_pkg::acc_w-1:0] out_data,
  output logic                               out_last,
  input  wire logic                          out_ack
);

  typedef enum logic [1:0] {
    em_idle = 2'd0,  // Holding register empty.
    em_req  = 2'd1,  // Request raised, waiting for ack.
    em_wait = 2'd2   // Waiting for ack to drop.
  } em_state_e;

  em_state_e state;

  // A result in flight from the column stage counts as occupied.
  assign res_ready = (state == em_idle) && !res_valid;
  assign out_req   = (state == em_req);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= em_idle;
    end else begin
      case (state)
        em_idle: if (res_valid) state <= em_req;
        em_req:  if (out_ack) state <= em_wait;
        em_wait: if (!out_ack) state <= em_idle;
        default: state <= em_idle;
      endcase
    end
  end

  // Data stays put for the whole handshake.
  always_ff @(posedge clk) begin
    if (state == em_idle && res_valid) begin
      out_data <= res_data;
      out_last <= res_last;
    end
  end

endmodule

`default_nettype wire

/* rtl/row_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module row_sequencer #(
  parameter int COLS = 16,
  parameter int ROWS = 4
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    pix_valid,
  input  wire logic                    res_ready,
  output logic                         pix_take,
  output logic                         clr_en,
  output logic                         ld_en,
  output logic                         sum_en,
  output logic                         cum_en,
  output logic                         row_last,
  output logic [$clog2(COLS)-1:0]      col_idx,
  output logic                         frame_done
);

  localparam int col_w = $clog2(COLS);
  localparam int row_w = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam logic [col_w-1:0] last_col = col_w'(COLS - 1);
  localparam logic [col_w-1:0] fill_end = col_w'(box_sum_pkg::win - 2);
  localparam logic [row_w-1:0] last_row = row_w'(ROWS - 1);

  box_sum_pkg::seq_state_e state, next_state;
  logic [col_w-1:0] col_cnt;
  logic [row_w-1:0] row_cnt;
  logic [col_w-1:0] acc_col;
  logic             take;

  // In accumulate, at most one result may be in the pipeline.
  assign take = (state == box_sum_pkg::st_fill && pix_valid) ||
                (state == box_sum_pkg::st_accum && pix_valid && res_ready && !cum_en);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= box_sum_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      box_sum_pkg::st_idle:      if (pix_valid) next_state = box_sum_pkg::st_clear;
      box_sum_pkg::st_clear:     if (col_cnt == last_col) next_state = box_sum_pkg::st_row_start;
      box_sum_pkg::st_row_start: next_state = box_sum_pkg::st_fill;
      box_sum_pkg::st_fill:      if (take && col_cnt == fill_end) next_state = box_sum_pkg::st_accum;
      box_sum_pkg::st_accum: begin
        if (take && col_cnt == last_col) begin
          next_state = (row_cnt == last_row) ? box_sum_pkg::st_finish
                                             : box_sum_pkg::st_row_start;
        end
      end
      box_sum_pkg::st_finish:    next_state = box_sum_pkg::st_idle;
      default:                   next_state = box_sum_pkg::st_idle;
    endcase
  end

  // ##########################################################
  // Stage enables
  // ##########################################################

  always_comb begin
    pix_take   = take;
    clr_en     = (state == box_sum_pkg::st_clear);
    ld_en      = (state == box_sum_pkg::st_row_start);
    sum_en     = (state == box_sum_pkg::st_fill) || (state == box_sum_pkg::st_accum);
    frame_done = (state == box_sum_pkg::st_finish);
  end

  assign col_idx = (state == box_sum_pkg::st_clear) ? col_cnt : acc_col;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else begin
      case (state)
        box_sum_pkg::st_clear: begin
          col_cnt <= (col_cnt == last_col) ? '0 : col_cnt + 1'b1;
          row_cnt <= '0;
        end
        box_sum_pkg::st_row_start: col_cnt <= '0;
        box_sum_pkg::st_fill, box_sum_pkg::st_accum: begin
          if (take && col_cnt == last_col) begin
            col_cnt <= '0;
            row_cnt <= row_cnt + 1'b1;  // Wraps unused after the last row.
          end else if (take) begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
        default: col_cnt <= '0;
      endcase
    end
  end

  // cum_en trails the take by one cycle, when win_sum has settled.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cum_en   <= 1'b0;
      acc_col  <= '0;
      row_last <= 1'b0;
    end else begin
      cum_en <= take && (state == box_sum_pkg::st_accum);
      if (take) begin
        acc_col  <= col_cnt;
        row_last <= (row_cnt == last_row);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/window_summer.sv */
`timescale 1ns/10ps
`default_nettype none

module window_summer (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          ld_en,
  input  wire logic                          shift_en,
  input  wire logic                          sum_en,
  input  wire logic [box_sum_pkg::pix_w-1:0] pix_data,
  output logic      [box_sum_pkg::acc_w-1:0] win_sum
);

  localparam int ext_w = box_sum_pkg::acc_w - box_sum_pkg::pix_w;

  logic [box_sum_pkg::pix_w-1:0] win_q [0:box_sum_pkg::win-1];
  logic [box_sum_pkg::acc_w-1:0] sum_q;
  logic [box_sum_pkg::acc_w-1:0] new_ext;
  logic [box_sum_pkg::acc_w-1:0] old_ext;
  logic                          step;

  assign step    = shift_en && sum_en;
  assign new_ext = {{ext_w{1'b0}}, pix_data};
  assign old_ext = {{ext_w{1'b0}}, win_q[box_sum_pkg::win-1]};  // Pixel leaving the window.
  assign win_sum = sum_q;

  // ##########################################################
  // Pixel window
  // ##########################################################

  always_ff @(posedge clk) begin
    if (ld_en) begin
      for (int i = 0; i < box_sum_pkg::win; i++) begin
        win_q[i] <= '0;
      end
    end else if (step) begin
      win_q[0] <= pix_data;
      for (int i = 1; i < box_sum_pkg::win; i++) begin
        win_q[i] <= win_q[i-1];
      end
    end
  end

  // ##########################################################
  // Running sum
  // ##########################################################

  // Add the newcomer and drop the oldest, so the sum never rescans the window.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (ld_en) begin
      sum_q <= '0;  // New row.
    end else if (step) begin
      sum_q <= sum_q + new_ext - old_ext;
    end
  end

endmodule

`default_nettype wire

/* test/box_sum_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module box_sum_checker #(
  parameter int COLS = 16,
  parameter int ROWS = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          in_req,
  input  wire logic [box_sum_pkg::pix_w-1:0] in_data,
  input  wire logic                          in_ack,
  input  wire logic                          out_req,
  input  wire logic [box_sum_pkg::acc_w-1:0] out_data,
  input  wire logic                          out_last,
  input  wire logic                          out_ack,
  input  wire logic                          frame_done,
  input  wire logic                          run_end,
  output int                                 value_errs,
  output int                                 proto_errs,
  output int                                 count_errs
);

  localparam int first_col = box_sum_pkg::win - 1;
  localparam int frame_pix = COLS * ROWS;

  logic [box_sum_pkg::pix_w-1:0] row_pix [0:COLS-1];  // Current row as seen so far.
  logic [box_sum_pkg::acc_w-1:0] col_sum [0:COLS-1];
  logic [box_sum_pkg::acc_w-1:0] exp_data [$];
  logic                          exp_last [$];
  logic [box_sum_pkg::acc_w-1:0] win_total;
  logic [box_sum_pkg::acc_w-1:0] want_data;
  logic                          want_last;
  int                            pix_cnt;
  int                            res_cnt;
  int                            done_cnt;
  int                            col;
  int                            row;
  logic                          end_seen;
  logic                          in_req_d;
  logic                          in_ack_d;
  logic                          out_req_d;
  logic                          out_ack_d;
  logic                          frame_done_d;
  logic [box_sum_pkg::acc_w-1:0] out_data_d;
  logic                          out_last_d;
  box_sum_pkg::seq_state_e       done_state = box_sum_pkg::st_finish;

  // ##########################################################
  // Reference model and result compare
  // ##########################################################

  always @(posedge clk) begin
    if (!rst_n) begin
      pix_cnt    = 0;
      res_cnt    = 0;
      value_errs = 0;
      count_errs = 0;
      end_seen   = 1'b0;
      exp_data.delete();
      exp_last.delete();
    end else begin
      if (in_ack && !in_ack_d) begin  // Pixel accepted.
        col = pix_cnt % COLS;
        row = (pix_cnt / COLS) % ROWS;
        if (col == 0 && row == 0) begin
          for (int k = 0; k < COLS; k++) begin
            col_sum[k] = '0;  // New frame.
          end
        end
        row_pix[col] = in_data;
        if (col >= first_col) begin
          win_total = '0;
          for (int k = col - first_col; k <= col; k++) begin
            win_total = win_total + row_pix[k];
          end
          col_sum[col] = col_sum[col] + win_total;
          exp_data.push_back(col_sum[col]);
          exp_last.push_back(row == ROWS - 1 && col == COLS - 1);
        end
        pix_cnt++;
      end
      if (out_req && out_ack) begin
        if (exp_data.size() == 0) begin
          $display("At %0d ns an extra result %0d came out with no pixel window behind it",
                   $time, out_data);
          count_errs++;
        end else begin
          want_data = exp_data.pop_front();
          want_last = exp_last.pop_front();
          if (out_data !== want_data) begin
            $display("[FAIL] %0d ns: result %0d is %0d, expected %0d",
                     $time, res_cnt, out_data, want_data);
            value_errs++;
          end
          if (out_last !== want_last) begin
            $display("[FAIL] %0d ns: result %0d has last flag %0b, expected %0b",
                     $time, res_cnt, out_last, want_last);
            value_errs++;
          end
          res_cnt++;
        end
      end
      if (run_end && !end_seen) begin
        end_seen = 1'b1;
        if (exp_data.size() != 0) begin
          $display("%0d results never came out", exp_data.size());
          count_errs++;
        end
        if (pix_cnt % frame_pix != 0) begin
          $display("%0d pixels accepted, which is not a whole number of frames", pix_cnt);
          count_errs++;
        end
        if (done_cnt != pix_cnt / frame_pix) begin
          $display("frame_done pulsed %0d times for %0d frames", done_cnt, pix_cnt / frame_pix);
          count_errs++;
        end
      end
    end
  end

  // ##########################################################
  // Handshake rules
  // ##########################################################

  always @(posedge clk) begin
    if (!rst_n) begin
      proto_errs = 0;
      done_cnt   = 0;
    end else begin
      if (in_ack && !in_ack_d && !in_req) begin
        $display("At %0d ns in_ack rose while in_req was low", $time);
        proto_errs++;
      end
      if (!in_ack && in_ack_d && in_req_d) begin
        $display("At %0d ns in_ack fell before in_req was withdrawn", $time);
        proto_errs++;
      end
      if (out_req_d && !out_req && !out_ack_d) begin
        $display("At %0d ns out_req dropped without an out_ack", $time);
        proto_errs++;
      end
      if (out_req_d && out_req && (out_data !== out_data_d || out_last !== out_last_d)) begin
        $display("At %0d ns out_data changed while out_req was high", $time);
        proto_errs++;
      end
      if (out_req && !out_req_d && out_ack) begin
        $display("At %0d ns out_req rose before out_ack was released", $time);
        proto_errs++;
      end
      if (frame_done && !frame_done_d) done_cnt++;
      if (frame_done && frame_done_d) begin
        $display("At %0d ns frame_done lasted more than one cycle of %s",
                 $time, done_state.name());
        proto_errs++;
      end
    end
    in_req_d     <= in_req;
    in_ack_d     <= in_ack;
    out_req_d    <= out_req;
    out_ack_d    <= out_ack;
    out_data_d   <= out_data;
    out_last_d   <= out_last;
    frame_done_d <= frame_done;
  end

endmodule

`default_nettype wire

/* test/box_sum_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module box_sum_tb;

  localparam int cols       = 16;
  localparam int rows       = 4;
  localparam int frames     = 3;
  localparam int n_pixels   = frames * cols * rows;
  localparam int n_results  = frames * rows * (cols - (box_sum_pkg::win - 1));
  localparam int timeout_ns = n_pixels * 20 * 10 + 2000;  // 20 cycles per pixel at most.

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          in_req;
  logic [box_sum_pkg::pix_w-1:0] in_data;
  logic                          in_ack;
  logic                          out_req;
  logic [box_sum_pkg::acc_w-1:0] out_data;
  logic                          out_last;
  logic                          out_ack;
  logic                          frame_done;
  logic                          run_end;
  int                            value_errs;
  int                            proto_errs;
  int                            count_errs;
  int                            acks_done;
  int                            seed     = 32'hec3b;
  int                            ack_seed = 32'hec3b;  // Own stream for the acknowledger.
  logic [31:0]                   pix_rnd;
  logic [31:0]                   ack_rnd;

  always #5 clk = ~clk;

  box_sum_top #(.COLS(cols), .ROWS(rows)) dut (
    .clk(clk), .rst_n(rst_n),
    .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
    .out_req(out_req), .out_data(out_data), .out_last(out_last),
    .out_ack(out_ack), .frame_done(frame_done)
  );

  box_sum_checker #(.COLS(cols), .ROWS(rows)) u_checker (
    .clk(clk), .rst_n(rst_n),
    .in_req(in_req), .in_data(in_data), .in_ack(in_ack),
    .out_req(out_req), .out_data(out_data), .out_last(out_last),
    .out_ack(out_ack), .frame_done(frame_done), .run_end(run_end),
    .value_errs(value_errs), .proto_errs(proto_errs), .count_errs(count_errs)
  );

  // Full four-phase cycle for one pixel.
  task automatic send_pixel(input logic [box_sum_pkg::pix_w-1:0] value);
    in_data <= value;
    in_req  <= 1'b1;
    @(posedge clk);
    while (!in_ack) @(posedge clk);
    in_req <= 1'b0;
    @(posedge clk);
    while (in_ack) @(posedge clk);
  endtask

  task automatic report_counts();
    $display("Errors: value %0d, protocol %0d, count %0d", value_errs, proto_errs, count_errs);
  endtask

  // ##########################################################
  // Reset and pixel stream
  // ##########################################################

  initial begin
    rst_n     = 1'b0;
    in_req    = 1'b0;
    in_data   = '0;
    out_ack   = 1'b0;
    run_end   = 1'b0;
    acks_done = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int n = 0; n < n_pixels; n++) begin
      pix_rnd = $random(seed);
      repeat (pix_rnd[9:8]) @(posedge clk);  // Idle gap of 0 to 3 cycles.
      send_pixel(pix_rnd[box_sum_pkg::pix_w-1:0]);
    end
    while (acks_done < n_results) @(posedge clk);
    repeat (30) @(posedge clk);  // Room for stray results.
    run_end <= 1'b1;
    repeat (2) @(posedge clk);
    report_counts();
    if (value_errs + proto_errs + count_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // ##########################################################
  // Output acknowledger
  // ##########################################################

  initial begin
    wait (rst_n === 1'b1);
    @(posedge clk);
    forever begin
      while (!out_req) @(posedge clk);
      ack_rnd = $random(ack_seed);
      repeat (ack_rnd % 6) @(posedge clk);
      out_ack <= 1'b1;
      @(posedge clk);
      while (out_req) @(posedge clk);
      repeat ((ack_rnd >> 8) % 6) @(posedge clk);  // Ack lingers after out_req drops.
      out_ack   <= 1'b0;
      acks_done <= acks_done + 1;
    end
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    report_counts();
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
